// ==== flist.f ====
hdl/fetch_pkg.sv
hdl/pc_reg.sv
hdl/btb.sv
hdl/fetch_csr.sv
hdl/inst_queue.sv
hdl/fetch_top.sv
test/fetch_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_frontend

sources:
  - hdl/fetch_pkg.sv
  - hdl/pc_reg.sv
  - hdl/btb.sv
  - hdl/fetch_csr.sv
  - hdl/inst_queue.sv
  - hdl/fetch_top.sv
  - target: test
    files:
      - test/fetch_tb.sv

// ==== test/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb;
    import fetch_pkg::*;

    // memory pattern, every address gives a distinct word
    localparam logic [31:0] mem_xor = 32'ha5a5_a5a5;
    localparam logic [31:0] br_pc   = 32'h1c00_0100;
    localparam logic [31:0] br_tgt  = 32'h1c00_0200;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic [addr_w-1:0] inst_rdata = '0;
    logic pop = 1'b0;
    logic branch_flush = 1'b0;
    logic [addr_w-1:0] branch_target = '0;
    br_update_t br_update = '0;
    csr_wr_t csr_wr = '0;
    logic excp_commit = 1'b0;
    logic ertn_commit = 1'b0;
    logic int_req = 1'b0;
    logic [addr_w-1:0] inst_addr;
    logic inst_en;
    fetch_entry_t head;
    logic head_valid;

    // reference model state
    logic [31:0] exp_pc;
    logic exp_int;
    logic redir_req = 1'b0;
    logic [31:0] redir_pc = '0;
    logic redir_int = 1'b0;
    logic m_valid = 1'b0;
    logic [31:0] m_pc = '0;
    logic [31:0] m_target = '0;
    logic [1:0] m_cnt = '0;
    logic [31:0] eentry_m = '0;
    logic [31:0] era_m = '0;
    logic [31:0] mem_q = '0;
    logic exp_taken;
    logic [5:0] exp_ecode;
    logic chk;
    logic holding = 1'b0;
    int hold_cnt;
    int popped;
    int pop_mode = 0;
    logic [15:0] lfsr = 16'd89;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int err_start;
    int pop_start;
    bit aborted = 0;

    fetch_top dut0 (.*);

    always #2 clk = ~clk;

    // one-cycle memory, sampled and returned on falling edges
    always @(negedge clk) begin
        inst_rdata <= mem_q;
        mem_q <= inst_addr ^ mem_xor;
    end

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    // single trained btb entry, hit compares pc above bit 1
    assign exp_taken = m_valid && (exp_pc[31:2] == m_pc[31:2]) && (m_cnt >= 2'd2);
    assign exp_ecode = exp_int ? ecode_int : ((exp_pc[1:0] != 2'b00) ? ecode_adef : ecode_none);
    assign chk = pop && head_valid;

    always @(posedge clk) begin
        if (rst) begin
            exp_pc <= reset_pc;
            exp_int <= 1'b0;
            popped <= 0;
        end else if (redir_req) begin
            exp_pc <= redir_pc;
            exp_int <= redir_int;
        end else if (chk) begin
            popped <= popped + 1;
            // taken prediction skips to the stored target
            exp_pc <= exp_taken ? m_target : exp_pc + 32'd4;
        end
        hold_cnt <= holding ? hold_cnt + 1 : 0;
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    a_reset_fetch: assert property (@(posedge clk) $fell(rst) |-> !inst_en)
        else begin
            errors++;
            $display("Fetch enabled in the first cycle out of reset at %0t", $time);
        end

    a_head_pc: assert property (@(posedge clk) disable iff (rst) chk |-> head.pc == exp_pc)
        else begin
            errors++;
            $display("Mismatch at %0t: head pc %h, expected %h", $time,
                     $sampled(head.pc), $sampled(exp_pc));
        end

    a_head_inst: assert property (@(posedge clk) disable iff (rst)
        chk |-> head.inst == (exp_pc ^ mem_xor))
        else begin
            errors++;
            $display("Mismatch at %0t: inst %h at pc %h", $time,
                     $sampled(head.inst), $sampled(exp_pc));
        end

    a_head_flags: assert property (@(posedge clk) disable iff (rst)
        chk |-> (head.pred_taken == exp_taken) && (head.is_interrupt == exp_int)
                && (head.is_adef == (exp_pc[1:0] != 2'b00)) && (head.ecode == exp_ecode))
        else begin
            errors++;
            $display("Mismatch at %0t: flags pt %b int %b adef %b ecode %h at pc %h", $time,
                     $sampled(head.pred_taken), $sampled(head.is_interrupt),
                     $sampled(head.is_adef), $sampled(head.ecode), $sampled(exp_pc));
        end

    // queue full by now, fetch must have stopped
    a_backpressure: assert property (@(posedge clk) disable iff (rst)
        (hold_cnt >= 12) |-> (!inst_en && head_valid))
        else begin
            errors++;
            $display("Fetch kept running or queue ran dry with pops withheld at %0t", $time);
        end

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // one clock, pulses cleared, pop chosen by mode
    task automatic drive_cycle();
        @(negedge clk);
        branch_flush = 1'b0;
        excp_commit = 1'b0;
        ertn_commit = 1'b0;
        csr_wr = '0;
        br_update = '0;
        redir_req = 1'b0;
        if (pop_mode == 2) begin
            lfsr = lfsr_step(lfsr);
            pop = lfsr[0];
        end else begin
            pop = (pop_mode == 1);
        end
    endtask

    // redirect cycle, no pop alongside it
    task automatic redirect(input logic [31:0] t, input logic intr, input int kind);
        drive_cycle();
        pop = 1'b0;
        redir_req = 1'b1;
        redir_pc = t;
        redir_int = intr;
        if (kind == 0) begin
            branch_flush = 1'b1;
            branch_target = t;
        end else if (kind == 1) begin
            excp_commit = 1'b1;
        end else begin
            ertn_commit = 1'b1;
        end
    endtask

    task automatic write_csr(input logic [13:0] a, input logic [31:0] d);
        drive_cycle();
        csr_wr = '{en: 1'b1, addr: a, data: d};
        if (a == csr_eentry) eentry_m = d;
        if (a == csr_era) era_m = d;
    endtask

    task automatic train_btb(input logic [31:0] p, input logic [31:0] t);
        drive_cycle();
        pop = 1'b0;
        br_update = '{valid: 1'b1, pc: p, target: t, taken: 1'b1};
        // miss allocates weakly not-taken, hit steps the counter
        if (!m_valid || m_pc[31:2] != p[31:2]) begin
            m_valid = 1'b1;
            m_pc = p;
            m_target = t;
            m_cnt = 2'd1;
        end else begin
            if (m_cnt != 2'd3) m_cnt = m_cnt + 2'd1;
            m_target = t;
        end
    endtask

    task automatic pop_entries(input int n);
        int target;
        int cyc;
        target = popped + n;
        for (cyc = 0; cyc < n * 8 + 40 && popped < target; cyc++) begin
            drive_cycle();
        end
        if (popped < target) begin
            aborted = 1;
            $display("Timeout: only %0d of %0d entries popped", n - (target - popped), n);
        end
    endtask

    task automatic wait_head();
        int cyc;
        for (cyc = 0; cyc < 40 && !head_valid; cyc++) begin
            drive_cycle();
        end
        if (!head_valid) begin
            aborted = 1;
            $display("Timeout: queue never received an instruction");
        end
    endtask

    task automatic start_test();
        err_start = errors;
        pop_start = popped;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != err_start) tests_failed++;
        $display("test %0d %s: %0d entries checked, %0d errors", tests_run, name,
                 popped - pop_start, errors - err_start);
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        repeat (5) @(negedge clk);
        rst = 1'b0;

        start_test();
        pop_mode = 1;
        pop_entries(12);
        end_test("sequential fetch");

        if (!aborted) begin
            start_test();
            pop_mode = 0;
            wait_head();
            redirect(32'h1c00_0800, 1'b0, 0);
            pop_mode = 1;
            pop_entries(6);
            redirect(32'h1c00_1001, 1'b0, 0);
            pop_entries(6);
            end_test("branch flush and adef");
        end

        if (!aborted) begin
            start_test();
            pop_mode = 0;
            train_btb(br_pc, br_tgt);
            redirect(br_pc - 32'd8, 1'b0, 0);
            pop_mode = 1;
            pop_entries(6);
            pop_mode = 0;
            train_btb(br_pc, br_tgt);
            redirect(br_pc - 32'd8, 1'b0, 0);
            pop_mode = 1;
            pop_entries(6);
            end_test("btb training");
        end

        if (!aborted) begin
            start_test();
            pop_mode = 0;
            write_csr(csr_eentry, 32'h1c00_4000);
            write_csr(csr_era, 32'h1c00_6000);
            redirect(eentry_m, 1'b0, 1);
            pop_mode = 1;
            pop_entries(5);
            redirect(era_m, 1'b0, 2);
            pop_entries(5);
            // interrupt enable plus pending request
            write_csr(csr_crmd, 32'h0000_0004);
            int_req = 1'b1;
            redirect(eentry_m, 1'b1, 1);
            pop_entries(5);
            int_req = 1'b0;
            redirect(32'h1c00_5000, 1'b0, 0);
            pop_entries(5);
            end_test("csr redirects and interrupt");
        end

        if (!aborted) begin
            start_test();
            pop_mode = 0;
            redirect(32'h1c00_8000, 1'b0, 0);
            holding = 1'b1;
            repeat (16) drive_cycle();
            holding = 1'b0;
            pop_mode = 2;
            pop_entries(40);
            end_test("back-pressure and random pops");
        end

        $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (aborted || errors != 0) begin
            $display("Simulation finished: FAIL");
        end else begin
            $display("Simulation finished: PASS");
        end
        $finish;
    end

endmodule

// ==== hdl/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [fetch_pkg::addr_w-1:0] inst_rdata,
    input  logic                         pop,
    input  logic                         branch_flush,
    input  logic [fetch_pkg::addr_w-1:0] branch_target,
    input  fetch_pkg::br_update_t        br_update,
    input  fetch_pkg::csr_wr_t           csr_wr,
    input  logic                         excp_commit,
    input  logic                         ertn_commit,
    input  logic                         int_req,
    output logic [fetch_pkg::addr_w-1:0] inst_addr,
    output logic                         inst_en,
    output fetch_pkg::fetch_entry_t      head,
    output logic                         head_valid
);
    import fetch_pkg::*;

    logic [addr_w-1:0] pc;
    pc_tag_t           tag;
    bp_pred_t          bp;
    ctrl_pc_t          ctrl_pc;
    logic              stall;
    logic              flush;

    // any redirect empties the queue
    assign flush     = branch_flush || ctrl_pc.exception_flush;
    assign inst_addr = pc;

    pc_reg pc_reg0 (
        .clk           (clk),
        .rst           (rst),
        .stall         (stall),
        .bp            (bp),
        .branch_flush  (branch_flush),
        .branch_target (branch_target),
        .ctrl_pc       (ctrl_pc),
        .pc            (pc),
        .tag           (tag),
        .fetch_en      (inst_en)
    );

    // lookup on the pc being fetched this cycle
    btb btb0 (
        .clk       (clk),
        .rst       (rst),
        .lookup_pc (pc),
        .pred      (bp),
        .upd       (br_update)
    );

    fetch_csr fetch_csr0 (
        .clk         (clk),
        .rst         (rst),
        .csr_wr      (csr_wr),
        .excp_commit (excp_commit),
        .ertn_commit (ertn_commit),
        .int_req     (int_req),
        .ctrl_pc     (ctrl_pc)
    );

    inst_queue inst_queue0 (
        .clk        (clk),
        .rst        (rst),
        .issue      (inst_en),
        .issue_tag  (tag),
        .rdata      (inst_rdata),
        .flush      (flush),
        .pop        (pop),
        .head       (head),
        .head_valid (head_valid),
        .stall      (stall)
    );

endmodule

// ==== hdl/inst_queue.sv ====
`timescale 1ns/1ps

module inst_queue (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         issue,
    input  fetch_pkg::pc_tag_t           issue_tag,
    input  logic [fetch_pkg::addr_w-1:0] rdata,
    input  logic                         flush,
    input  logic                         pop,
    output fetch_pkg::fetch_entry_t      head,
    output logic                         head_valid,
    output logic                         stall
);
    import fetch_pkg::*;

    // fetch issued last cycle, data arrives now
    logic                   pend_valid;
    pc_tag_t                pend_tag;

    fetch_entry_t           mem [queue_depth];
    logic [queue_ptr_w-1:0] wr_ptr;
    logic [queue_ptr_w-1:0] rd_ptr;
    logic [queue_cnt_w-1:0] count;

    logic                   push;
    logic                   pop_ok;
    fetch_entry_t           push_entry;

    ////////////////////////////////////////
    // in-flight fetch tracking
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pend_valid <= 1'b0;
        end else begin
            // flush in the issuing cycle drops it
            pend_valid <= issue && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            pend_tag <= issue_tag;
        end
    end

    // flush in the returning cycle drops it too
    assign push   = pend_valid && !flush;
    assign pop_ok = pop && (count != '0);

    always_comb begin
        push_entry.pc           = pend_tag.pc;
        push_entry.inst         = rdata;
        push_entry.pred_taken   = pend_tag.pred_taken;
        push_entry.is_interrupt = pend_tag.is_interrupt;
        push_entry.is_adef      = pend_tag.is_adef;
        push_entry.ecode        = pend_tag.ecode;
    end

    ////////////////////////////////////////
    // circular buffer
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap, depth is a power of two
            wr_ptr <= wr_ptr + queue_ptr_w'(push);
            rd_ptr <= rd_ptr + queue_ptr_w'(pop_ok);
            count  <= count + queue_cnt_w'(push) - queue_cnt_w'(pop_ok);
        end
    end

    assign head       = mem[rd_ptr];
    assign head_valid = (count != '0);

    // keep one slot for the fetch already in flight
    // flush empties the queue so no stall is needed then
    assign stall = (count >= queue_cnt_w'(queue_depth - 1)) && !flush;

    // early stall must leave room for the returning fetch
    a_no_push_full: assert property (
        @(posedge clk) disable iff (rst)
        push |-> (count < queue_cnt_w'(queue_depth))
    );

    a_count_bound: assert property (
        @(posedge clk) disable iff (rst)
        count <= queue_cnt_w'(queue_depth)
    );

endmodule

// ==== hdl/fetch_csr.sv ====
`timescale 1ns/1ps

module fetch_csr (
    input  logic                  clk,
    input  logic                  rst,
    input  fetch_pkg::csr_wr_t    csr_wr,
    input  logic                  excp_commit,
    input  logic                  ertn_commit,
    input  logic                  int_req,
    output fetch_pkg::ctrl_pc_t   ctrl_pc
);
    import fetch_pkg::*;

    // exception entry vector
    logic [addr_w-1:0] eentry;
    // return address for ertn
    logic [addr_w-1:0] era;
    // crmd.ie only, other crmd fields live in the backend
    logic              ie;

    ////////////////////////////////////////
    // csr write port
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            eentry <= '0;
            era    <= '0;
            ie     <= 1'b0;
        end else if (csr_wr.en) begin
            case (csr_wr.addr)
                csr_eentry: begin
                    eentry <= csr_wr.data;
                end
                csr_era: begin
                    era <= csr_wr.data;
                end
                csr_crmd: begin
                    ie <= csr_wr.data[crmd_ie_bit];
                end
                default: begin
                    // not held here
                    ie <= ie;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // redirect generation
    ////////////////////////////////////////

    always_comb begin
        // one cycle per commit pulse
        ctrl_pc.exception_flush = excp_commit || ertn_commit;
        // exception wins over ertn
        if (excp_commit) begin
            ctrl_pc.new_pc = eentry;
        end else begin
            ctrl_pc.new_pc = era;
        end
        // level, tags every fetch while pending
        ctrl_pc.is_interrupt = int_req && ie;
    end

    // backend commits one instruction at a time
    a_one_commit: assert property (
        @(posedge clk) disable iff (rst)
        !(excp_commit && ertn_commit)
    );

endmodule

// ==== hdl/btb.sv ====
`timescale 1ns/1ps

module btb (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [fetch_pkg::addr_w-1:0] lookup_pc,
    output fetch_pkg::bp_pred_t          pred,
    input  fetch_pkg::br_update_t        upd
);
    import fetch_pkg::*;

    // valid bits carry the reset, the rest is payload
    logic [btb_entries-1:0] valid_q;
    logic [btb_tag_w-1:0]   tag_q [btb_entries];
    logic [addr_w-1:0]      target_q [btb_entries];
    logic [1:0]             cnt_q [btb_entries];

    logic [btb_idx_w-1:0]   lk_idx;
    logic [btb_tag_w-1:0]   lk_tag;
    logic                   lk_hit;

    logic [btb_idx_w-1:0]   up_idx;
    logic [btb_tag_w-1:0]   up_tag;
    logic                   up_hit;
    logic [1:0]             cnt_next;

    ////////////////////////////////////////
    // lookup
    ////////////////////////////////////////

    // pc[1:0] ignored, index just above
    assign lk_idx = lookup_pc[btb_idx_w+1:2];
    assign lk_tag = lookup_pc[addr_w-1:btb_idx_w+2];
    assign lk_hit = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);

    // weakly or strongly taken
    assign pred.hit_taken = lk_hit && cnt_q[lk_idx][1];
    assign pred.target    = target_q[lk_idx];

    ////////////////////////////////////////
    // update
    ////////////////////////////////////////

    assign up_idx = upd.pc[btb_idx_w+1:2];
    assign up_tag = upd.pc[addr_w-1:btb_idx_w+2];
    assign up_hit = valid_q[up_idx] && (tag_q[up_idx] == up_tag);

    // saturating 2-bit counter step
    always_comb begin
        cnt_next = cnt_q[up_idx];
        if (upd.taken) begin
            if (cnt_q[up_idx] != 2'b11) begin
                cnt_next = cnt_q[up_idx] + 2'b01;
            end
        end else begin
            if (cnt_q[up_idx] != 2'b00) begin
                cnt_next = cnt_q[up_idx] - 2'b01;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (upd.valid) begin
            valid_q[up_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (upd.valid) begin
            if (up_hit) begin
                cnt_q[up_idx] <= cnt_next;
                // retarget only on a taken outcome
                if (upd.taken) begin
                    target_q[up_idx] <= upd.target;
                end
            end else begin
                // first sighting allocates weakly not-taken
                tag_q[up_idx]    <= up_tag;
                target_q[up_idx] <= upd.target;
                cnt_q[up_idx]    <= 2'b01;
            end
        end
    end

endmodule

// ==== hdl/pc_reg.sv ====
`timescale 1ns/1ps

module pc_reg (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         stall,
    input  fetch_pkg::bp_pred_t          bp,
    input  logic                         branch_flush,
    input  logic [fetch_pkg::addr_w-1:0] branch_target,
    input  fetch_pkg::ctrl_pc_t          ctrl_pc,
    output logic [fetch_pkg::addr_w-1:0] pc,
    output fetch_pkg::pc_tag_t           tag,
    output logic                         fetch_en
);
    import fetch_pkg::*;

    // goes high one cycle after reset is released
    logic started;
    logic misaligned;

    ////////////////////////////////////////
    // fetch enable
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            started <= 1'b0;
        end else begin
            started <= 1'b1;
        end
    end

    // no fetch while a redirect is in progress or the queue is near full
    assign fetch_en = started && !stall && !branch_flush && !ctrl_pc.exception_flush;

    ////////////////////////////////////////
    // next pc selection
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_pc;
        end else if (ctrl_pc.exception_flush) begin
            // exception entry or ertn beats everything
            pc <= ctrl_pc.new_pc;
        end else if (stall || !started) begin
            // hold until started so reset_pc is fetched once
            pc <= pc;
        end else if (branch_flush) begin
            pc <= branch_target;
        end else if (bp.hit_taken) begin
            // btb predicts taken so follow the stored target
            pc <= bp.target;
        end else begin
            pc <= pc + 32'd4;
        end
    end

    ////////////////////////////////////////
    // exception tagging of the current pc
    ////////////////////////////////////////

    assign misaligned = (pc[1:0] != 2'b00);

    always_comb begin
        tag.pc           = pc;
        tag.pred_taken   = bp.hit_taken;
        tag.is_interrupt = ctrl_pc.is_interrupt;
        tag.is_adef      = misaligned;
        // interrupt outranks adef
        if (ctrl_pc.is_interrupt) begin
            tag.ecode = ecode_int;
        end else if (misaligned) begin
            tag.ecode = ecode_adef;
        end else begin
            tag.ecode = ecode_none;
        end
    end

    // a pc step without an issued fetch would skip an instruction
    a_no_skip: assert property (
        @(posedge clk) disable iff (rst)
        (!fetch_en && !branch_flush && !ctrl_pc.exception_flush) |=> (pc == $past(pc))
    );

endmodule

// ==== hdl/fetch_pkg.sv ====
package fetch_pkg;

    ////////////////////////////////////////
    // widths and reset state
    ////////////////////////////////////////

    // address and instruction word width
    localparam int addr_w = 32;
    // first fetch after reset
    localparam logic [addr_w-1:0] reset_pc = 32'h1c00_0000;

    // direct-mapped btb, index from pc[5:2]
    localparam int btb_entries = 16;
    localparam int btb_idx_w = $clog2(btb_entries);
    // tag is everything above the index
    localparam int btb_tag_w = addr_w - btb_idx_w - 2;

    // fetch queue sizing
    localparam int queue_depth = 8;
    localparam int queue_ptr_w = $clog2(queue_depth);
    // one extra bit so a full queue is representable
    localparam int queue_cnt_w = queue_ptr_w + 1;

    ////////////////////////////////////////
    // csr addresses and exception codes
    ////////////////////////////////////////

    localparam logic [13:0] csr_crmd   = 14'h000;
    localparam logic [13:0] csr_era    = 14'h006;
    localparam logic [13:0] csr_eentry = 14'h00c;
    // global interrupt enable inside crmd
    localparam int crmd_ie_bit = 2;

    localparam logic [5:0] ecode_int  = 6'h00;
    localparam logic [5:0] ecode_adef = 6'h08;
    // no exception on this entry
    localparam logic [5:0] ecode_none = 6'h3f;

    ////////////////////////////////////////
    // shared structs
    ////////////////////////////////////////

    // one queued instruction for decode
    typedef struct packed {
        logic [addr_w-1:0] pc;
        logic [addr_w-1:0] inst;
        logic              pred_taken;
        logic              is_interrupt;
        logic              is_adef;
        logic [5:0]        ecode;
    } fetch_entry_t;

    // tag for the pc being fetched, inst joins later
    typedef struct packed {
        logic [addr_w-1:0] pc;
        logic              pred_taken;
        logic              is_interrupt;
        logic              is_adef;
        logic [5:0]        ecode;
    } pc_tag_t;

    typedef struct packed {
        logic              en;
        logic [13:0]       addr;
        logic [addr_w-1:0] data;
    } csr_wr_t;

    // redirect request from the csr block
    typedef struct packed {
        logic              exception_flush;
        logic [addr_w-1:0] new_pc;
        logic              is_interrupt;
    } ctrl_pc_t;

    // resolved branch from the backend
    typedef struct packed {
        logic              valid;
        logic [addr_w-1:0] pc;
        logic [addr_w-1:0] target;
        logic              taken;
    } br_update_t;

    typedef struct packed {
        logic              hit_taken;
        logic [addr_w-1:0] target;
    } bp_pred_t;

endpackage
